// File: alu_core/alu_core.sv
//**************************************************************************
// ALU core with an idle, execute and result FSM, flag logic and clear
//**************************************************************************

`timescale 1ns/1ps

module alu_core (
    input  logic clk,
    input  logic rst,
    alu_if.core  alu
);

    localparam int msb = alu_pkg::word_msb;

    alu_pkg::alu_state_t state_q;

    // Operands captured on start
    alu_pkg::word_t   a_q;
    alu_pkg::word_t   b_q;
    alu_pkg::alu_op_t op_q;

    logic [alu_pkg::data_width:0]   tmp_q;   // Result with carry out in the top bit
    logic [alu_pkg::prod_width-1:0] prod_q;

    logic [alu_pkg::data_width:0]   exec_res;
    logic [alu_pkg::prod_width-1:0] exec_prod;
    alu_pkg::flags_t                flags_calc;
    logic                           carry;
    logic                           overflow;

    // Datapath evaluated during execute
    always_comb begin
        exec_prod = a_q * b_q;
        case (op_q)
            alu_pkg::op_add: exec_res = {1'b0, a_q} + {1'b0, b_q};
            alu_pkg::op_sub: exec_res = {1'b0, a_q} - {1'b0, b_q};  // Bit 16 is the borrow
            alu_pkg::op_and: exec_res = {1'b0, a_q & b_q};
            alu_pkg::op_or:  exec_res = {1'b0, a_q | b_q};
            alu_pkg::op_xor: exec_res = {1'b0, a_q ^ b_q};
            alu_pkg::op_not: exec_res = {1'b0, ~a_q};
            alu_pkg::op_shl: exec_res = {a_q, 1'b0};
            alu_pkg::op_shr: exec_res = {2'b00, a_q[msb:1]};
            alu_pkg::op_slt: exec_res = {{alu_pkg::data_width{1'b0}},
                                         ($signed(a_q) < $signed(b_q))};
            alu_pkg::op_eq:  exec_res = {{alu_pkg::data_width{1'b0}}, (a_q == b_q)};
            alu_pkg::op_mul: exec_res = {1'b0, exec_prod[msb:0]};
            alu_pkg::op_div: begin
                if (b_q != '0) begin
                    exec_res = {1'b0, a_q / b_q};
                end else begin
                    exec_res = '1;
                end
            end
            default: exec_res = '0;  // Unknown code
        endcase
    end

    // Flags from the registered result
    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (op_q)
            alu_pkg::op_add: begin
                carry    = tmp_q[alu_pkg::data_width];
                overflow = (a_q[msb] == b_q[msb]) && (tmp_q[msb] != a_q[msb]);
            end
            alu_pkg::op_sub: begin
                carry    = tmp_q[alu_pkg::data_width];
                overflow = (a_q[msb] != b_q[msb]) && (tmp_q[msb] != a_q[msb]);
            end
            alu_pkg::op_shl: begin
                carry    = a_q[msb];
                overflow = a_q[msb] ^ a_q[msb-1];  // Sign changed by the shift
            end
            alu_pkg::op_mul: begin
                carry    = prod_q[alu_pkg::prod_width-1:alu_pkg::data_width] != '0;
                overflow = carry;
            end
            default: begin
                carry    = 1'b0;
                overflow = 1'b0;
            end
        endcase
        flags_calc = {(tmp_q[msb:0] == '0), carry, overflow, tmp_q[msb]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= alu_pkg::st_idle;
            a_q     <= '0;
            b_q     <= '0;
            op_q    <= '0;
            tmp_q   <= '0;
            prod_q  <= '0;
        end else if (alu.clear) begin
            // Abort and wipe the datapath
            state_q <= alu_pkg::st_idle;
            a_q     <= '0;
            b_q     <= '0;
            op_q    <= '0;
            tmp_q   <= '0;
            prod_q  <= '0;
        end else begin
            case (state_q)
                alu_pkg::st_idle: begin
                    if (alu.start) begin
                        a_q     <= alu.operand_a;
                        b_q     <= alu.operand_b;
                        op_q    <= alu.op;
                        state_q <= alu_pkg::st_execute;
                    end
                end
                alu_pkg::st_execute: begin
                    tmp_q   <= exec_res;
                    prod_q  <= exec_prod;
                    state_q <= alu_pkg::st_result;
                end
                alu_pkg::st_result: state_q <= alu_pkg::st_idle;
                default:            state_q <= alu_pkg::st_idle;
            endcase
        end
    end

    assign alu.result = tmp_q[msb:0];
    assign alu.flags  = (state_q == alu_pkg::st_result) ? flags_calc : '0;
    assign alu.done   = (state_q == alu_pkg::st_result);
    assign alu.busy   = (state_q != alu_pkg::st_idle);  // Execute and result

endmodule

// File: common/alu_if.sv
//**************************************************************************
// ALU link between the register block, the ALU core and the monitor
//**************************************************************************

`timescale 1ns/1ps

interface alu_if;

    alu_pkg::word_t   operand_a;
    alu_pkg::word_t   operand_b;
    alu_pkg::alu_op_t op;
    logic             start;     // One-cycle request
    alu_pkg::word_t   result;
    alu_pkg::flags_t  flags;
    logic             done;      // One-cycle completion
    logic             busy;
    logic             clear;     // Abort from the sequence monitor

    modport regs (
        output operand_a, operand_b, op, start,
        input  result, flags, done, busy, clear
    );

    modport core (
        input  operand_a, operand_b, op, start, clear,
        output result, flags, done, busy
    );

    modport monitor (
        input  operand_a,
        output clear
    );

endinterface

// File: common/alu_pkg.sv
//**************************************************************************
// ALU peripheral package with widths, opcodes, register map and core states
//**************************************************************************

package alu_pkg;

    // Operand width and derived bit positions
    localparam int data_width = 16;
    localparam int word_msb   = data_width - 1;
    localparam int prod_width = 2 * data_width;  // Full multiplier output

    typedef logic [data_width-1:0] word_t;

    // Zero in bit 3, carry in 2, overflow in 1, negative in 0
    typedef logic [3:0] flags_t;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t op_add = 4'd0;
    localparam alu_op_t op_sub = 4'd1;
    localparam alu_op_t op_and = 4'd2;
    localparam alu_op_t op_or  = 4'd3;
    localparam alu_op_t op_xor = 4'd4;
    localparam alu_op_t op_not = 4'd5;
    localparam alu_op_t op_shl = 4'd6;
    localparam alu_op_t op_shr = 4'd7;
    localparam alu_op_t op_slt = 4'd8;   // Signed compare
    localparam alu_op_t op_eq  = 4'd9;
    localparam alu_op_t op_mul = 4'd10;  // Low half kept
    localparam alu_op_t op_div = 4'd11;  // Divide by zero gives all ones

    // Word addresses on the Wishbone bus
    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t reg_a          = 3'd0;
    localparam reg_addr_t reg_b          = 3'd1;
    localparam reg_addr_t reg_op         = 3'd2;
    localparam reg_addr_t reg_ctrl       = 3'd3;
    localparam reg_addr_t reg_result     = 3'd4;
    localparam reg_addr_t reg_status     = 3'd5;
    localparam reg_addr_t reg_pattern_lo = 3'd6;  // Pattern bytes 0 and 1
    localparam reg_addr_t reg_pattern_hi = 3'd7;  // Pattern byte 2

    typedef enum logic [1:0] {
        st_idle,
        st_execute,
        st_result
    } alu_state_t;

endpackage

// File: source/alu_host_top.sv
//**************************************************************************
// ALU peripheral top that joins the register block, core and sequence monitor
//**************************************************************************

`timescale 1ns/1ps

module alu_host_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  alu_pkg::reg_addr_t wb_adr,
    input  alu_pkg::word_t     wb_dat_i,
    output alu_pkg::word_t     wb_dat_o,
    output logic               wb_ack,
    output logic               alarm
);

    logic        a_write;
    logic        alarm_clr;
    logic [23:0] pattern;

    alu_if alu_bus ();

    wb_alu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .alu       (alu_bus.regs),
        .alarm     (alarm),
        .alarm_clr (alarm_clr),
        .a_write   (a_write),
        .pattern   (pattern)
    );

    alu_core u_core (
        .clk (clk),
        .rst (rst),
        .alu (alu_bus.core)
    );

    seq_monitor u_monitor (
        .clk       (clk),
        .rst       (rst),
        .alu       (alu_bus.monitor),
        .a_write   (a_write),
        .pattern   (pattern),
        .alarm_clr (alarm_clr),
        .alarm     (alarm)
    );

endmodule

// File: source/seq_monitor.sv
//**************************************************************************
// Sequence monitor that clears the ALU and raises alarm on a three-byte match
//**************************************************************************

`timescale 1ns/1ps

module seq_monitor (
    input  logic        clk,
    input  logic        rst,
    alu_if.monitor      alu,
    input  logic        a_write,    // Operand A was written
    input  logic [23:0] pattern,    // Byte 0 is matched first
    input  logic        alarm_clr,
    output logic        alarm
);

    logic [1:0] match_cnt;
    logic [7:0] a_byte;
    logic [7:0] expect_byte;
    logic       enabled;
    logic       clear_q;

    assign a_byte  = alu.operand_a[7:0];
    assign enabled = (pattern != '0);  // All zeros turns the monitor off

    always_comb begin
        case (match_cnt)
            2'd0:    expect_byte = pattern[7:0];
            2'd1:    expect_byte = pattern[15:8];
            default: expect_byte = pattern[23:16];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_cnt <= 2'd0;
            clear_q   <= 1'b0;
            alarm     <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            if (alarm_clr) begin
                alarm <= 1'b0;
            end

            if (!enabled) begin
                match_cnt <= 2'd0;
            end else if (a_write) begin
                if (a_byte == expect_byte) begin
                    if (match_cnt == 2'd2) begin
                        match_cnt <= 2'd0;
                        clear_q   <= 1'b1;
                        alarm     <= 1'b1;  // Set overrides a same-cycle clear
                    end else begin
                        match_cnt <= match_cnt + 2'd1;
                    end
                end else begin
                    // Mismatch may still open a new sequence
                    match_cnt <= (a_byte == pattern[7:0]) ? 2'd1 : 2'd0;
                end
            end
        end
    end

    assign alu.clear = clear_q;

endmodule

// File: source/wb_alu_regs.sv
//**************************************************************************
// Wishbone classic slave with operand, opcode, pattern and status registers
//**************************************************************************

`timescale 1ns/1ps

module wb_alu_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  alu_pkg::reg_addr_t wb_adr,
    input  alu_pkg::word_t     wb_dat_i,
    output alu_pkg::word_t     wb_dat_o,
    output logic               wb_ack,
    alu_if.regs                alu,
    input  logic               alarm,
    output logic               alarm_clr,  // Write of 0 to status
    output logic               a_write,
    output logic [23:0]        pattern
);

    alu_pkg::word_t   operand_a_q;
    alu_pkg::word_t   operand_b_q;
    alu_pkg::alu_op_t op_q;
    alu_pkg::word_t   result_q;
    alu_pkg::flags_t  flags_q;
    logic             valid_q;
    logic             start_q;
    logic             bus_req;
    logic             wr_req;
    alu_pkg::word_t   status_word;
    alu_pkg::word_t   read_data;

    // Ack holds off a second request in the cycle it is high
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_req  = bus_req && wb_we;

    assign status_word = {9'b0, alarm, alu.busy, valid_q, flags_q};

    always_comb begin
        case (wb_adr)
            alu_pkg::reg_a:          read_data = operand_a_q;
            alu_pkg::reg_b:          read_data = operand_b_q;
            alu_pkg::reg_op:         read_data = alu_pkg::word_t'(op_q);
            alu_pkg::reg_result:     read_data = result_q;
            alu_pkg::reg_status:     read_data = status_word;
            alu_pkg::reg_pattern_lo: read_data = pattern[15:0];
            alu_pkg::reg_pattern_hi: read_data = alu_pkg::word_t'(pattern[23:16]);
            default:                 read_data = '0;  // Control reads as zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            wb_dat_o    <= '0;
            start_q     <= 1'b0;
            a_write     <= 1'b0;
            alarm_clr   <= 1'b0;
            operand_a_q <= '0;
            operand_b_q <= '0;
            op_q        <= '0;
            pattern     <= '0;
            result_q    <= '0;
            flags_q     <= '0;
            valid_q     <= 1'b0;
        end else begin
            wb_ack    <= bus_req;
            // Strobes line up with the ack cycle
            start_q   <= wr_req && (wb_adr == alu_pkg::reg_ctrl) && wb_dat_i[0] && !alu.busy;
            a_write   <= wr_req && (wb_adr == alu_pkg::reg_a);
            alarm_clr <= wr_req && (wb_adr == alu_pkg::reg_status) && (wb_dat_i == '0);

            if (bus_req) begin
                wb_dat_o <= wb_we ? '0 : read_data;
            end

            if (wr_req) begin
                case (wb_adr)
                    alu_pkg::reg_a:          operand_a_q    <= wb_dat_i;
                    alu_pkg::reg_b:          operand_b_q    <= wb_dat_i;
                    alu_pkg::reg_op:         op_q           <= wb_dat_i[3:0];
                    alu_pkg::reg_pattern_lo: pattern[15:0]  <= wb_dat_i;
                    alu_pkg::reg_pattern_hi: pattern[23:16] <= wb_dat_i[7:0];
                    default: ;
                endcase
            end

            // Monitor clear wins over result capture
            if (alu.clear) begin
                result_q <= '0;
                flags_q  <= '0;
                valid_q  <= 1'b0;
            end else if (alu.done) begin
                result_q <= alu.result;
                flags_q  <= alu.flags;
                valid_q  <= 1'b1;
            end else if (start_q) begin
                valid_q  <= 1'b0;
            end
        end
    end

    assign alu.operand_a = operand_a_q;
    assign alu.operand_b = operand_b_q;
    assign alu.op        = op_q;
    assign alu.start     = start_q;

endmodule

// File: tests/wb_bus_tasks.svh
//**************************************************************************
// Wishbone classic master tasks for the ALU peripheral testbench
//**************************************************************************

`ifndef WB_BUS_TASKS_SVH
`define WB_BUS_TASKS_SVH

localparam int ack_limit = 16;  // Cycles allowed for a slave ack

// Samples ack on each rising edge and ends the bus cycle once it is seen
task automatic wait_for_ack(input alu_pkg::reg_addr_t adr, output logic acked);
    int waited;
    waited = 0;
    acked  = 1'b0;
    while (!acked && waited < ack_limit) begin
        @(posedge clk);
        acked  = wb_ack;
        waited = waited + 1;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked) begin
        bus_errors = bus_errors + 1;
        $display("Bus error: no ack within %0d cycles at address %0d", ack_limit, adr);
    end
endtask

task automatic bus_write(input alu_pkg::reg_addr_t adr, input alu_pkg::word_t data);
    logic acked;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= data;
    wait_for_ack(adr, acked);
endtask

task automatic bus_read(input alu_pkg::reg_addr_t adr, output alu_pkg::word_t data);
    logic acked;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_for_ack(adr, acked);
    data = acked ? wb_dat_o : '0;  // Read data is valid in the ack cycle
endtask

`endif

// File: tests/alu_host_tb.sv
//**************************************************************************
// Testbench for the ALU peripheral with file, random, busy and monitor cases
//**************************************************************************

`timescale 1ns/1ps

module alu_host_tb;

    localparam int random_cases = 200;
    localparam int extra_cases  = 4;   // Reset, busy start, monitor setup, monitor match
    localparam int poll_limit   = 10;

    logic               clk;
    logic               rst;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    alu_pkg::reg_addr_t wb_adr;
    alu_pkg::word_t     wb_dat_i;
    alu_pkg::word_t     wb_dat_o;
    logic               wb_ack;
    logic               alarm;

    int          check_errors;
    int          bus_errors;
    int          watchdog_cycles;
    logic        cases_loaded;
    logic [15:0] lfsr_state;

    // Cases from the data file
    alu_pkg::alu_op_t case_op[$];
    alu_pkg::word_t   case_a[$];
    alu_pkg::word_t   case_b[$];
    alu_pkg::word_t   case_res[$];
    alu_pkg::flags_t  case_flags[$];

    alu_host_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .alarm    (alarm)
    );

    `include "wb_bus_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        wait (cases_loaded === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic compare_word(input string name, input alu_pkg::word_t expected,
                                input alu_pkg::word_t actual);
        if (actual !== expected) begin
            check_errors = check_errors + 1;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_flags(input string name, input alu_pkg::flags_t expected,
                                 input alu_pkg::flags_t actual);
        if (actual !== expected) begin
            check_errors = check_errors + 1;
            $display("[FAIL] %s flags: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            check_errors = check_errors + 1;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic alu_pkg::word_t random_bits(input int count);
        alu_pkg::word_t val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            val = {val[14:0], next_random_bit()};
        end
        return val;
    endfunction

    function automatic alu_pkg::alu_op_t random_op();
        case (random_bits(2))
            16'd0:   return alu_pkg::op_add;
            16'd1:   return alu_pkg::op_sub;
            16'd2:   return alu_pkg::op_xor;
            default: return alu_pkg::op_slt;
        endcase
    endfunction

    // Reference model for the random operations
    task automatic compute_expected(input alu_pkg::alu_op_t op, input alu_pkg::word_t a,
                                    input alu_pkg::word_t b, output alu_pkg::word_t res,
                                    output alu_pkg::flags_t flg);
        logic [16:0] sum;
        logic        carry;
        logic        ovf;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            alu_pkg::op_add: begin
                sum   = a + b;
                res   = sum[15:0];
                carry = sum[16];
                ovf   = (a[15] == b[15]) && (res[15] != a[15]);
            end
            alu_pkg::op_sub: begin
                res   = a - b;
                carry = (a < b);  // Borrow
                ovf   = (a[15] != b[15]) && (res[15] != a[15]);
            end
            alu_pkg::op_xor: res = a ^ b;
            alu_pkg::op_slt: res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default:         res = '0;
        endcase
        flg = {(res == 16'd0), carry, ovf, res[15]};
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [15:0] op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] flg;
        fd = $fopen("tests/alu_input.txt", "r");
        if (fd == 0) begin
            check_errors = check_errors + 1;
            $display("Cannot open the case file tests/alu_input.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", op, a, b, res, flg);
                    if (n == 5) begin
                        case_op.push_back(op[3:0]);
                        case_a.push_back(a);
                        case_b.push_back(b);
                        case_res.push_back(res);
                        case_flags.push_back(flg[3:0]);
                    end
                end
            end
            $fclose(fd);
            if (case_op.size() == 0) begin
                check_errors = check_errors + 1;
                $display("No cases were read from tests/alu_input.txt");
            end
        end
    endtask

    task automatic run_case(input string name, input alu_pkg::alu_op_t op,
                            input alu_pkg::word_t a, input alu_pkg::word_t b,
                            input alu_pkg::word_t res, input alu_pkg::flags_t flg);
        alu_pkg::word_t status;
        alu_pkg::word_t result;
        int             polls;
        bus_write(alu_pkg::reg_a, a);
        bus_write(alu_pkg::reg_b, b);
        bus_write(alu_pkg::reg_op, alu_pkg::word_t'(op));
        bus_write(alu_pkg::reg_ctrl, 16'h0001);
        polls  = 0;
        status = '0;
        while (!status[4] && polls < poll_limit) begin  // Valid bit
            bus_read(alu_pkg::reg_status, status);
            polls = polls + 1;
        end
        if (!status[4]) begin
            check_errors = check_errors + 1;
            $display("Result of %s never became valid", name);
        end else begin
            bus_read(alu_pkg::reg_result, result);
            compare_word(name, res, result);
            compare_flags(name, flg, status[3:0]);
        end
    endtask

    task automatic check_reset_values();
        alu_pkg::word_t data;
        for (int adr = 0; adr < 8; adr++) begin
            bus_read(alu_pkg::reg_addr_t'(adr), data);
            compare_word($sformatf("reset register %0d", adr), 16'h0000, data);
        end
        compare_bit("reset alarm", 1'b0, alarm);
    endtask

    task automatic check_busy_start();
        alu_pkg::word_t status;
        alu_pkg::word_t result;
        alu_pkg::word_t data;
        bus_write(alu_pkg::reg_a, 16'h1234);
        bus_write(alu_pkg::reg_b, 16'h0101);
        bus_write(alu_pkg::reg_op, alu_pkg::word_t'(alu_pkg::op_sub));
        bus_write(alu_pkg::reg_ctrl, 16'h0001);
        bus_write(alu_pkg::reg_ctrl, 16'h0001);  // Lands while the core is in result
        bus_read(alu_pkg::reg_status, status);
        compare_word("busy start status", 16'h0010, status);
        bus_read(alu_pkg::reg_result, result);
        compare_word("busy start result", 16'h1133, result);
        // Operand and opcode readback
        bus_read(alu_pkg::reg_a, data);
        compare_word("operand a readback", 16'h1234, data);
        bus_read(alu_pkg::reg_b, data);
        compare_word("operand b readback", 16'h0101, data);
        bus_read(alu_pkg::reg_op, data);
        compare_word("opcode readback", 16'h0001, data);
    endtask

    task automatic check_monitor();
        alu_pkg::word_t status;
        alu_pkg::word_t data;
        run_case("monitor setup", alu_pkg::op_or, 16'h0f00, 16'h0003, 16'h0f03, 4'b0000);
        bus_write(alu_pkg::reg_pattern_lo, 16'h3c5a);
        bus_write(alu_pkg::reg_pattern_hi, 16'h00a5);
        bus_read(alu_pkg::reg_pattern_lo, data);
        compare_word("pattern low readback", 16'h3c5a, data);
        bus_read(alu_pkg::reg_pattern_hi, data);
        compare_word("pattern high readback", 16'h00a5, data);
        // Third byte one off
        bus_write(alu_pkg::reg_a, 16'h005a);
        bus_write(alu_pkg::reg_a, 16'h003c);
        bus_write(alu_pkg::reg_a, 16'h00a6);
        bus_read(alu_pkg::reg_status, status);
        compare_word("near miss status", 16'h0010, status);
        compare_bit("near miss alarm", 1'b0, alarm);
        bus_write(alu_pkg::reg_a, 16'h115a);
        bus_write(alu_pkg::reg_a, 16'h223c);
        bus_write(alu_pkg::reg_a, 16'h33a5);
        bus_read(alu_pkg::reg_status, status);
        compare_word("match status", 16'h0040, status);  // Alarm set, valid gone
        compare_bit("match alarm", 1'b1, alarm);
        bus_write(alu_pkg::reg_status, 16'h0000);
        bus_read(alu_pkg::reg_status, status);
        compare_word("alarm cleared status", 16'h0000, status);
        compare_bit("alarm cleared", 1'b0, alarm);
    endtask

    initial begin : main
        alu_pkg::alu_op_t op;
        alu_pkg::word_t   a;
        alu_pkg::word_t   b;
        alu_pkg::word_t   res;
        alu_pkg::flags_t  flg;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = '0;
        check_errors = 0;
        bus_errors   = 0;
        cases_loaded = 1'b0;
        lfsr_state   = 16'd94;
        load_cases();
        watchdog_cycles = (case_op.size() + random_cases + extra_cases) * 40 + 2000;
        cases_loaded    = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        check_reset_values();
        foreach (case_op[i]) begin
            run_case($sformatf("file case %0d", i), case_op[i], case_a[i], case_b[i],
                     case_res[i], case_flags[i]);
        end
        for (int i = 0; i < random_cases; i++) begin
            op = random_op();
            a  = random_bits(16);
            b  = random_bits(16);
            compute_expected(op, a, b, res, flg);
            run_case($sformatf("random case %0d", i), op, a, b, res, flg);
        end
        check_busy_start();
        check_monitor();
        repeat (4) @(posedge clk);
        $display("Errors: %0d check, %0d bus", check_errors, bus_errors);
        if (check_errors == 0 && bus_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/alu_input.txt
# Columns in hex: op, operand A, operand B, expected result, expected flags
# Flags are zero, carry, overflow, negative from bit 3 down to bit 0
0 0003 0004 0007 0
0 7fff 0001 8000 3
0 ffff 0001 0000 c
1 0005 0003 0002 0
1 0003 0005 fffe 5
1 8000 0001 7fff 2
2 f0f0 ff00 f000 1
3 0f00 00f0 0ff0 0
4 aaaa aaaa 0000 8
5 00ff 0000 ff00 1
6 c001 0000 8002 5
6 4000 0000 8000 3
7 8001 0000 4000 0
8 8000 0001 0001 0
8 0001 8000 0000 8
9 1234 1234 0001 0
a 0010 0020 0200 0
a 0100 0100 0000 e
a ffff 0002 fffe 7
b 0064 0007 000e 0
b 1234 0000 ffff 1
c 1234 5678 0000 8

// File: verilog.f
+incdir+tests
common/alu_pkg.sv
common/alu_if.sv
alu_core/alu_core.sv
source/wb_alu_regs.sv
source/seq_monitor.sv
source/alu_host_top.sv
tests/alu_host_tb.sv
